// ==== Bender.yml ====
package:
  name: usb_packet_codec

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/usb_pkg.sv
      - rtl/usb_stream_if.sv
      - rtl/usb_crc16.sv
      - rtl/usb_stream_fifo.sv
      - rtl/encode_packet.sv
      - rtl/decode_packet.sv
      - rtl/usb_packet_codec.sv
  - target: test
    files:
      - tests/usb_packet_codec_chk.sv
      - tests/usb_packet_codec_tb.sv

// ==== rtl/decode_packet.sv ====
`timescale 1ns/1ps
module decode_packet import usb_pkg::*; (
  input  logic       clock,
  input  logic       rst_n_i,
  usb_stream_if.snk  rx_i,
  output logic       tok_recv_o,
  output tok_type_t  tok_type_o,
  output logic [6:0] tok_addr_o,
  output logic [3:0] tok_endp_o,
  output logic       usb_sof_o,
  output logic       hsk_recv_o,
  output hsk_type_t  hsk_type_o,
  output logic       crc_err_o,
  output logic       pay_valid_o,
  input  logic       pay_ready_i,
  output rx_beat_t   pay_data_o
);

  // Byte index within the packet, saturates at 3
  logic [1:0]  cnt_q;
  logic [3:0]  pid_q;
  logic        pid_ok_q;
  logic [7:0]  tok_b1_q;
  logic [7:0]  dly0_q;
  logic [7:0]  dly1_q;
  logic        fire;
  logic        first;
  logic        last_fire;
  logic [3:0]  pid_w;
  logic        pid_ok_w;
  logic        is_tok;
  logic        is_hsk;
  logic        is_dat;
  logic        crc5_ok;
  logic        crc16_ok;
  logic        pkt_good;
  logic [15:0] crc_w;

  assign rx_i.tready = pay_ready_i;
  assign fire        = rx_i.tvalid && rx_i.tready;
  assign first       = (cnt_q == 2'd0);
  assign last_fire   = fire && rx_i.tlast;

  // On the PID byte itself, look at the incoming byte directly
  assign pid_w    = first ? rx_i.tdata[3:0] : pid_q;
  assign pid_ok_w = first ? (rx_i.tdata[7:4] == ~rx_i.tdata[3:0]) : pid_ok_q;

  // Class checks include the length each class needs at tlast
  assign is_tok = pid_ok_w && (pid_w[1:0] == PID_TOK_LO) && (cnt_q == 2'd2);
  assign is_hsk = pid_ok_w && (pid_w[1:0] == PID_HSK_LO) && first && (pid_w[3:2] != 2'b01);
  assign is_dat = pid_ok_w && (pid_w[2:0] == PID_DAT_LO) && (cnt_q == 2'd3);

  assign crc5_ok  = (crc5_calc({rx_i.tdata[2:0], tok_b1_q}) == rx_i.tdata[7:3]);
  assign crc16_ok = (crc_w == CRC16_RESIDUAL);
  assign pkt_good = (is_tok && crc5_ok) || is_hsk || (is_dat && crc16_ok);

  usb_crc16 u_crc16 (
    .clock    (clock),
    .rst_n_i  (rst_n_i),
    .clear_i  (fire && first),
    .update_i (fire && !first),
    .data_i   (rx_i.tdata),
    .crc_o    (crc_w)
  );

  // Byte k writes byte k-2, so both CRC bytes stay behind.
  // A bad CRC16 drops the final beat and no tlast goes out
  assign pay_valid_o = fire && is_dat && (!rx_i.tlast || crc16_ok);
  assign pay_data_o  = '{dtype: dat_type_t'(pid_q[3]), last: rx_i.tlast, data: dly1_q};

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q      <= 2'd0;
      pid_q      <= '0;
      pid_ok_q   <= 1'b0;
      tok_recv_o <= 1'b0;
      usb_sof_o  <= 1'b0;
      hsk_recv_o <= 1'b0;
      crc_err_o  <= 1'b0;
    end else begin
      tok_recv_o <= last_fire && is_tok && crc5_ok && (pid_w[3:2] != TOK_SOF);
      usb_sof_o  <= last_fire && is_tok && crc5_ok && (pid_w[3:2] == TOK_SOF);
      hsk_recv_o <= last_fire && is_hsk;
      crc_err_o  <= last_fire && !pkt_good;
      if (last_fire) begin
        cnt_q <= 2'd0;
      end else if (fire && cnt_q != 2'd3) begin
        cnt_q <= cnt_q + 2'd1;
      end
      if (fire && first) begin
        pid_q    <= pid_w;
        pid_ok_q <= pid_ok_w;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (fire) begin
      dly0_q <= rx_i.tdata;
      dly1_q <= dly0_q;
    end
    if (fire && cnt_q == 2'd1) tok_b1_q <= rx_i.tdata;
    // Event fields, valid alongside their pulse
    if (last_fire && is_tok) begin
      tok_type_o <= tok_type_t'(pid_w[3:2]);
      tok_addr_o <= tok_b1_q[6:0];
      tok_endp_o <= {rx_i.tdata[2:0], tok_b1_q[7]};
    end
    if (last_fire && is_hsk) hsk_type_o <= hsk_type_t'(pid_w[3:2]);
  end

endmodule

// ==== rtl/encode_packet.sv ====
`timescale 1ns/1ps
module encode_packet import usb_pkg::*; (
  input  logic       clock,
  input  logic       rst_n_i,
  input  logic       hsk_send_i,
  input  hsk_type_t  hsk_type_i,
  output logic       hsk_done_o,
  input  logic       tok_send_i,
  input  tok_type_t  tok_type_i,
  input  logic [6:0] tok_addr_i,
  input  logic [3:0] tok_endp_i,
  output logic       tok_done_o,
  input  logic       dat_send_i,
  input  dat_type_t  dat_type_i,
  output logic       dat_done_o,
  input  logic       pay_valid_i,
  output logic       pay_ready_o,
  input  tx_beat_t   pay_data_i,
  usb_stream_if.src  tx_o
);

  typedef enum logic [2:0] {S_IDLE, S_TOK1, S_TOK2, S_DATA, S_CRC1, S_CRC2, S_LAST} state_t;
  typedef enum logic [1:0] {K_HSK, K_TOK, K_DAT} kind_t;

  state_t      state_q;
  kind_t       kind_q;
  logic        valid_q;
  logic        last_q;
  logic [7:0]  data_q;
  logic [15:0] tok_q;
  logic        out_free;
  logic        tx_fire;
  logic        start;
  logic        pay_fire;
  logic [15:0] crc_w;
  logic [15:0] crc_wire;

  assign tx_o.tvalid = valid_q;
  assign tx_o.tlast  = last_q;
  assign tx_o.tdata  = data_q;

  assign tx_fire  = valid_q && tx_o.tready;
  assign out_free = !valid_q || tx_o.tready;
  // Requests are ignored while a done pulse is out, the caller drops them then
  assign start    = (state_q == S_IDLE) && !(hsk_done_o || tok_done_o || dat_done_o)
                    && (hsk_send_i || tok_send_i || dat_send_i);
  assign pay_ready_o = (state_q == S_DATA) && out_free;
  assign pay_fire    = pay_valid_i && pay_ready_o;

  usb_crc16 u_crc16 (
    .clock    (clock),
    .rst_n_i  (rst_n_i),
    .clear_i  (start),
    .update_i (pay_fire),
    .data_i   (pay_data_i.data),
    .crc_o    (crc_w)
  );

  // Inverted and bit reversed, low byte goes out first
  always_comb begin
    for (int i = 0; i < 16; i++) begin
      crc_wire[i] = ~crc_w[15 - i];
    end
  end

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= S_IDLE;
      kind_q     <= K_HSK;
      valid_q    <= 1'b0;
      last_q     <= 1'b0;
      data_q     <= '0;
      hsk_done_o <= 1'b0;
      tok_done_o <= 1'b0;
      dat_done_o <= 1'b0;
    end else begin
      hsk_done_o <= 1'b0;
      tok_done_o <= 1'b0;
      dat_done_o <= 1'b0;
      case (state_q)
        S_IDLE: begin
          if (start) begin
            valid_q <= 1'b1;
            // Handshake first, then token, then data
            if (hsk_send_i) begin
              kind_q  <= K_HSK;
              data_q  <= pid_byte({hsk_type_i, PID_HSK_LO});
              last_q  <= 1'b1;
              state_q <= S_LAST;
            end else if (tok_send_i) begin
              kind_q  <= K_TOK;
              data_q  <= pid_byte({tok_type_i, PID_TOK_LO});
              last_q  <= 1'b0;
              state_q <= S_TOK1;
            end else begin
              kind_q  <= K_DAT;
              data_q  <= pid_byte({dat_type_i, PID_DAT_LO});
              last_q  <= 1'b0;
              state_q <= S_DATA;
            end
          end
        end
        S_TOK1: begin
          if (out_free) begin
            data_q  <= tok_q[7:0];
            state_q <= S_TOK2;
          end
        end
        S_TOK2: begin
          if (out_free) begin
            data_q  <= tok_q[15:8];
            last_q  <= 1'b1;
            state_q <= S_LAST;
          end
        end
        S_DATA: begin
          if (pay_fire) begin
            valid_q <= 1'b1;
            data_q  <= pay_data_i.data;
            if (pay_data_i.last) state_q <= S_CRC1;
          end else if (out_free) begin
            // TX FIFO ran dry mid-packet
            valid_q <= 1'b0;
          end
        end
        S_CRC1: begin
          if (out_free) begin
            valid_q <= 1'b1;
            data_q  <= crc_wire[7:0];
            state_q <= S_CRC2;
          end
        end
        S_CRC2: begin
          if (out_free) begin
            data_q  <= crc_wire[15:8];
            last_q  <= 1'b1;
            state_q <= S_LAST;
          end
        end
        default: begin
          if (tx_fire) begin
            valid_q    <= 1'b0;
            last_q     <= 1'b0;
            state_q    <= S_IDLE;
            hsk_done_o <= (kind_q == K_HSK);
            tok_done_o <= (kind_q == K_TOK);
            dat_done_o <= (kind_q == K_DAT);
          end
        end
      endcase
    end
  end

  // Token word is {crc5, endp, addr}, sent low byte first
  always_ff @(posedge clock) begin
    if (start) tok_q <= {crc5_calc({tok_endp_i, tok_addr_i}), tok_endp_i, tok_addr_i};
  end

endmodule

// ==== rtl/usb_config.svh ====
`ifndef USB_CONFIG_SVH
`define USB_CONFIG_SVH

// Entries in the transmit payload FIFO ahead of the encoder
`define USB_TX_FIFO_DEPTH 16

// Entries in the receive payload FIFO, phy_rx stalls once it is full
`define USB_RX_FIFO_DEPTH 16

`endif

// ==== rtl/usb_crc16.sv ====
`timescale 1ns/1ps
module usb_crc16 import usb_pkg::*; (
  input  logic        clock,
  input  logic        rst_n_i,
  input  logic        clear_i,
  input  logic        update_i,
  input  logic [7:0]  data_i,
  output logic [15:0] crc_o
);

  logic [15:0] crc_q;
  logic [15:0] crc_upd;

  // Fold one byte in, LSB first
  always_comb begin
    crc_upd = crc_q;
    for (int i = 0; i < 8; i++) begin
      if (data_i[i] ^ crc_upd[15]) begin
        crc_upd = {crc_upd[14:0], 1'b0} ^ CRC16_POLY;
      end else begin
        crc_upd = {crc_upd[14:0], 1'b0};
      end
    end
  end

  // Look-ahead value, already includes the byte folded in this cycle
  assign crc_o = clear_i  ? CRC16_SEED :
                 update_i ? crc_upd    : crc_q;

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      crc_q <= CRC16_SEED;
    end else begin
      crc_q <= crc_o;
    end
  end

endmodule

// ==== rtl/usb_packet_codec.sv ====
`timescale 1ns/1ps
`include "usb_config.svh"
module usb_packet_codec import usb_pkg::*; (
  input  logic       clock,
  input  logic       rst_n_i,
  input  logic       hsk_send_i,
  input  hsk_type_t  hsk_type_i,
  output logic       hsk_done_o,
  input  logic       tok_send_i,
  input  tok_type_t  tok_type_i,
  input  logic [6:0] tok_addr_i,
  input  logic [3:0] tok_endp_i,
  output logic       tok_done_o,
  input  logic       dat_send_i,
  input  dat_type_t  dat_type_i,
  output logic       dat_done_o,
  input  logic       dat_tvalid_i,
  output logic       dat_tready_o,
  input  logic       dat_tlast_i,
  input  logic [7:0] dat_tdata_i,
  output logic       usb_tx_tvalid_o,
  input  logic       usb_tx_tready_i,
  output logic       usb_tx_tlast_o,
  output logic [7:0] usb_tx_tdata_o,
  input  logic       usb_rx_tvalid_i,
  output logic       usb_rx_tready_o,
  input  logic       usb_rx_tlast_i,
  input  logic [7:0] usb_rx_tdata_i,
  output logic       tok_recv_o,
  output tok_type_t  tok_type_o,
  output logic [6:0] tok_addr_o,
  output logic [3:0] tok_endp_o,
  output logic       usb_sof_o,
  output logic       hsk_recv_o,
  output hsk_type_t  hsk_type_o,
  output logic       crc_err_o,
  output logic       out_tvalid_o,
  input  logic       out_tready_i,
  output logic       out_tlast_o,
  output dat_type_t  out_ttype_o,
  output logic [7:0] out_tdata_o
);

  usb_stream_if phy_tx ();
  usb_stream_if phy_rx ();

  tx_beat_t dat_beat;
  tx_beat_t enc_beat;
  logic     enc_valid;
  logic     enc_ready;
  rx_beat_t dec_beat;
  logic     dec_valid;
  logic     dec_ready;
  rx_beat_t out_beat;

  assign dat_beat        = '{last: dat_tlast_i, data: dat_tdata_i};
  assign usb_tx_tvalid_o = phy_tx.tvalid;
  assign usb_tx_tlast_o  = phy_tx.tlast;
  assign usb_tx_tdata_o  = phy_tx.tdata;
  assign phy_tx.tready   = usb_tx_tready_i;
  assign phy_rx.tvalid   = usb_rx_tvalid_i;
  assign phy_rx.tlast    = usb_rx_tlast_i;
  assign phy_rx.tdata    = usb_rx_tdata_i;
  assign usb_rx_tready_o = phy_rx.tready;
  assign out_tlast_o     = out_beat.last;
  assign out_ttype_o     = out_beat.dtype;
  assign out_tdata_o     = out_beat.data;

  usb_stream_fifo #(
    .T     (tx_beat_t),
    .DEPTH (`USB_TX_FIFO_DEPTH)
  ) u_tx_fifo (
    .clock      (clock),
    .rst_n_i    (rst_n_i),
    .wr_valid_i (dat_tvalid_i),
    .wr_ready_o (dat_tready_o),
    .wr_data_i  (dat_beat),
    .rd_valid_o (enc_valid),
    .rd_ready_i (enc_ready),
    .rd_data_o  (enc_beat)
  );

  encode_packet u_encode (
    .clock       (clock),
    .rst_n_i     (rst_n_i),
    .hsk_send_i  (hsk_send_i),
    .hsk_type_i  (hsk_type_i),
    .hsk_done_o  (hsk_done_o),
    .tok_send_i  (tok_send_i),
    .tok_type_i  (tok_type_i),
    .tok_addr_i  (tok_addr_i),
    .tok_endp_i  (tok_endp_i),
    .tok_done_o  (tok_done_o),
    .dat_send_i  (dat_send_i),
    .dat_type_i  (dat_type_i),
    .dat_done_o  (dat_done_o),
    .pay_valid_i (enc_valid),
    .pay_ready_o (enc_ready),
    .pay_data_i  (enc_beat),
    .tx_o        (phy_tx)
  );

  decode_packet u_decode (
    .clock       (clock),
    .rst_n_i     (rst_n_i),
    .rx_i        (phy_rx),
    .tok_recv_o  (tok_recv_o),
    .tok_type_o  (tok_type_o),
    .tok_addr_o  (tok_addr_o),
    .tok_endp_o  (tok_endp_o),
    .usb_sof_o   (usb_sof_o),
    .hsk_recv_o  (hsk_recv_o),
    .hsk_type_o  (hsk_type_o),
    .crc_err_o   (crc_err_o),
    .pay_valid_o (dec_valid),
    .pay_ready_i (dec_ready),
    .pay_data_o  (dec_beat)
  );

  usb_stream_fifo #(
    .T     (rx_beat_t),
    .DEPTH (`USB_RX_FIFO_DEPTH)
  ) u_rx_fifo (
    .clock      (clock),
    .rst_n_i    (rst_n_i),
    .wr_valid_i (dec_valid),
    .wr_ready_o (dec_ready),
    .wr_data_i  (dec_beat),
    .rd_valid_o (out_tvalid_o),
    .rd_ready_i (out_tready_i),
    .rd_data_o  (out_beat)
  );

endmodule

// ==== rtl/usb_pkg.sv ====
package usb_pkg;

  // PID nibble is {type, class}, the wire byte adds the complement on top
  typedef enum logic [1:0] {
    TOK_OUT   = 2'b00,
    TOK_SOF   = 2'b01,
    TOK_IN    = 2'b10,
    TOK_SETUP = 2'b11
  } tok_type_t;

  typedef enum logic [1:0] {
    HSK_ACK   = 2'b00,
    HSK_NAK   = 2'b10,
    HSK_STALL = 2'b11
  } hsk_type_t;

  typedef enum logic {
    DATA0 = 1'b0,
    DATA1 = 1'b1
  } dat_type_t;

  typedef struct packed {
    logic       last;
    logic [7:0] data;
  } tx_beat_t;

  typedef struct packed {
    dat_type_t  dtype;
    logic       last;
    logic [7:0] data;
  } rx_beat_t;

  // Low PID bits that select the packet class
  localparam logic [1:0] PID_TOK_LO = 2'b01;
  localparam logic [1:0] PID_HSK_LO = 2'b10;
  localparam logic [2:0] PID_DAT_LO = 3'b011;

  // CRC5 over {endp, addr}: poly x^5+x^2+1, seed all ones, LSB first
  localparam logic [4:0] CRC5_POLY = 5'h05;

  // CRC16: poly 0x8005, seed all ones, each byte LSB first into a
  // left-shifting register. The register is inverted and bit reversed,
  // so its top bit goes out first, and sent low byte first. Running the
  // same register over data and both CRC bytes leaves CRC16_RESIDUAL
  localparam logic [15:0] CRC16_POLY     = 16'h8005;
  localparam logic [15:0] CRC16_SEED     = 16'hffff;
  localparam logic [15:0] CRC16_RESIDUAL = 16'h800d;

  function automatic logic [7:0] pid_byte(input logic [3:0] pid);
    return {~pid, pid};
  endfunction

  // Returns the 5-bit field as it sits in bits [15:11] of the token
  function automatic logic [4:0] crc5_calc(input logic [10:0] din);
    logic [4:0] crc;
    logic [4:0] field;
    crc = 5'h1f;
    for (int i = 0; i < 11; i++) begin
      if (din[i] ^ crc[4]) begin
        crc = {crc[3:0], 1'b0} ^ CRC5_POLY;
      end else begin
        crc = {crc[3:0], 1'b0};
      end
    end
    // Inverted, highest-order bit first on the wire
    for (int i = 0; i < 5; i++) begin
      field[i] = ~crc[4 - i];
    end
    return field;
  endfunction

endpackage

// ==== rtl/usb_stream_fifo.sv ====
`timescale 1ns/1ps
module usb_stream_fifo #(
  parameter type         T     = logic [7:0],
  parameter int unsigned DEPTH = 16
) (
  input  logic clock,
  input  logic rst_n_i,
  input  logic wr_valid_i,
  output logic wr_ready_o,
  input  T     wr_data_i,
  output logic rd_valid_o,
  input  logic rd_ready_i,
  output T     rd_data_o
);

  localparam int unsigned AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  T              mem_q [DEPTH];
  logic [AW-1:0] wr_ptr_q;
  logic [AW-1:0] rd_ptr_q;
  logic [AW:0]   used_q;
  logic          wr_fire;
  logic          head_load;
  logic          bypass;
  logic          mem_wr;
  logic          mem_rd;

  function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
    return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign wr_ready_o = (used_q < (AW + 1)'(DEPTH));
  assign wr_fire    = wr_valid_i && wr_ready_o;
  // Head register takes a new entry when empty or being drained
  assign head_load  = !rd_valid_o || rd_ready_i;
  // Write straight into the head when the buffer behind it is empty
  assign bypass     = head_load && (used_q == '0) && wr_fire;
  assign mem_rd     = head_load && (used_q != '0);
  assign mem_wr     = wr_fire && !bypass;

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      used_q     <= '0;
      rd_valid_o <= 1'b0;
    end else begin
      if (mem_wr) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (mem_rd) rd_ptr_q <= ptr_inc(rd_ptr_q);
      if (mem_wr && !mem_rd) begin
        used_q <= used_q + 1'b1;
      end else if (mem_rd && !mem_wr) begin
        used_q <= used_q - 1'b1;
      end
      if (head_load) rd_valid_o <= mem_rd || bypass;
    end
  end

  always_ff @(posedge clock) begin
    if (mem_wr) mem_q[wr_ptr_q] <= wr_data_i;
    if (mem_rd) begin
      rd_data_o <= mem_q[rd_ptr_q];
    end else if (bypass) begin
      rd_data_o <= wr_data_i;
    end
  end

endmodule

// ==== rtl/usb_stream_if.sv ====
`timescale 1ns/1ps
// Byte stream with valid/ready/last between packet blocks and the PHY side
interface usb_stream_if;
  logic       tvalid;
  logic       tready;
  logic       tlast;
  logic [7:0] tdata;

  modport src (
    output tvalid,
    output tlast,
    output tdata,
    input  tready
  );

  modport snk (
    input  tvalid,
    input  tlast,
    input  tdata,
    output tready
  );
endinterface

// ==== tests/usb_packet_codec_chk.sv ====
`timescale 1ns/1ps
// Protocol checks on the packet blocks, bound into the encoder and decoder
module usb_packet_codec_chk (
  input logic       clock,
  input logic       rst_n_i,
  input logic       valid_i,
  input logic       fire_i,
  input logic       last_i,
  input logic [7:0] data_i,
  input logic [2:0] pulse_i,
  input logic [1:0] excl_i
);

  int unsigned fail_cnt = 0;

  // Offered byte holds until it transfers
  stream_hold: assert property (@(posedge clock) disable iff (!rst_n_i)
    valid_i && !fire_i |=> valid_i && $stable(data_i) && $stable(last_i))
  else begin
    $error("stream byte or tlast changed while stalled");
    fail_cnt++;
  end

  done_pulse: assert property (@(posedge clock) disable iff (!rst_n_i)
    (pulse_i != 3'b000) |=> (pulse_i == 3'b000))
  else begin
    $error("done output high for more than one cycle");
    fail_cnt++;
  end

  event_excl: assert property (@(posedge clock) disable iff (!rst_n_i)
    !(excl_i[1] && excl_i[0]))
  else begin
    $error("token and CRC error events fired together");
    fail_cnt++;
  end

endmodule

// ==== tests/usb_packet_codec_tb.sv ====
`timescale 1ns/1ps
module usb_packet_codec_tb import usb_pkg::*; ();

  localparam int          NROWS         = 16;
  localparam int          MAX_PKT_BYTES = 15;
  localparam int          TIMEOUT_NS    = NROWS * (MAX_PKT_BYTES + 40) * 4 * 2;
  localparam logic [31:0] SEED          = 32'd25;
  localparam logic [1:0]  KIND_HSK      = 2'd0;
  localparam logic [1:0]  KIND_TOK      = 2'd1;
  localparam logic [1:0]  KIND_DAT      = 2'd2;

  typedef struct packed {
    logic [1:0] kind;
    logic [1:0] typ;
    logic [6:0] addr;
    logic [3:0] endp;
    logic [3:0] len;
    logic       stall;
    logic       corrupt;
    logic [3:0] cbyte;
    logic [2:0] cbit;
  } row_t;

  logic clock = 1'b0;
  logic rst_n_i;
  logic hsk_send_i, hsk_done_o, tok_send_i, tok_done_o, dat_send_i, dat_done_o;
  hsk_type_t  hsk_type_i, hsk_type_o;
  tok_type_t  tok_type_i, tok_type_o;
  dat_type_t  dat_type_i, out_ttype_o;
  logic [6:0] tok_addr_i, tok_addr_o;
  logic [3:0] tok_endp_i, tok_endp_o;
  logic dat_tvalid_i, dat_tready_o, dat_tlast_i;
  logic [7:0] dat_tdata_i, usb_tx_tdata_o, usb_rx_tdata_i, out_tdata_o;
  logic usb_tx_tvalid_o, usb_tx_tready_i, usb_tx_tlast_o;
  logic usb_rx_tvalid_i, usb_rx_tready_o, usb_rx_tlast_i;
  logic tok_recv_o, usb_sof_o, hsk_recv_o, crc_err_o;
  logic out_tvalid_o, out_tready_i, out_tlast_o;

  // Loopback gate state
  logic        gate_stall = 1'b0;
  logic        hold_out = 1'b0;
  logic        corrupt_en = 1'b0;
  logic [3:0]  corrupt_byte = '0;
  logic [2:0]  corrupt_bit = '0;
  logic [3:0]  byte_idx = '0;
  logic [7:0]  flip_mask;
  logic [31:0] rng = SEED;
  logic [31:0] feed_rng = SEED;
  logic [31:0] gate_rng = SEED;

  row_t       rows [NROWS];
  logic [8:0] tx_seen [$];
  logic [9:0] exp_q [$];
  int         tok_cnt, sof_cnt, hsk_cnt, crc_err_cnt;
  tok_type_t  seen_tok_type;
  logic [6:0] seen_addr;
  logic [3:0] seen_endp;
  hsk_type_t  seen_hsk_type;

  usb_packet_codec UUT (.*);

  bind encode_packet usb_packet_codec_chk enc_chk (
    .clock(clock), .rst_n_i(rst_n_i), .valid_i(valid_q), .fire_i(tx_fire),
    .last_i(last_q), .data_i(data_q),
    .pulse_i({hsk_done_o, tok_done_o, dat_done_o}), .excl_i(2'b00));
  bind decode_packet usb_packet_codec_chk dec_chk (
    .clock(clock), .rst_n_i(rst_n_i), .valid_i(1'b0), .fire_i(1'b0),
    .last_i(1'b0), .data_i(8'h00), .pulse_i(3'b000), .excl_i({tok_recv_o, crc_err_o}));

  assign flip_mask       = (corrupt_en && byte_idx == corrupt_byte) ? (8'h01 << corrupt_bit) : 8'h00;
  assign usb_rx_tvalid_i = usb_tx_tvalid_o && !gate_stall;
  assign usb_tx_tready_i = usb_rx_tready_o && !gate_stall;
  assign usb_rx_tlast_i  = usb_tx_tlast_o;
  assign usb_rx_tdata_i  = usb_tx_tdata_o ^ flip_mask;

  always #2 clock = ~clock;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // PID values as listed in the USB 2.0 tables
  function automatic logic [7:0] make_pid(input logic [1:0] kind, input logic [1:0] typ);
    logic [3:0] n;
    if (kind == KIND_HSK) begin
      n = (typ == HSK_ACK) ? 4'b0010 : (typ == HSK_NAK) ? 4'b1010 : 4'b1110;
    end else if (kind == KIND_TOK) begin
      case (typ)
        TOK_OUT: n = 4'b0001;
        TOK_IN:  n = 4'b1001;
        TOK_SOF: n = 4'b0101;
        default: n = 4'b1101;
      endcase
    end else begin
      n = typ[0] ? 4'b1011 : 4'b0011;
    end
    return {~n, n};
  endfunction

  // Reflected CRC5, complement is the wire field
  function automatic logic [4:0] crc5_field(input logic [10:0] bits);
    logic [4:0] c;
    c = 5'h1f;
    for (int i = 0; i < 11; i++) begin
      c = (c[0] ^ bits[i]) ? ((c >> 1) ^ 5'h14) : (c >> 1);
    end
    return ~c;
  endfunction

  function automatic logic [15:0] crc16_step(input logic [15:0] crc, input logic [7:0] b);
    logic [15:0] c;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      c = (c[0] ^ b[i]) ? ((c >> 1) ^ 16'ha001) : (c >> 1);
    end
    return c;
  endfunction

  task automatic report_error(input string msg);
    $display("ERR %0t: %s", $time, msg);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic wait_tick();
    @(posedge clock);
    #1;
  endtask

  task automatic load_table();
    rows[0]  = '{KIND_TOK, TOK_OUT,   7'h05, 4'h1, 4'd0,  1'b0, 1'b0, 4'd0, 3'd0};
    rows[1]  = '{KIND_TOK, TOK_IN,    7'h7f, 4'hf, 4'd0,  1'b0, 1'b0, 4'd0, 3'd0};
    rows[2]  = '{KIND_TOK, TOK_SETUP, 7'h00, 4'h0, 4'd0,  1'b0, 1'b0, 4'd0, 3'd0};
    rows[3]  = '{KIND_TOK, TOK_SOF,   7'h2a, 4'h5, 4'd0,  1'b0, 1'b0, 4'd0, 3'd0};
    rows[4]  = '{KIND_HSK, HSK_ACK,   7'h00, 4'h0, 4'd0,  1'b0, 1'b0, 4'd0, 3'd0};
    rows[5]  = '{KIND_HSK, HSK_NAK,   7'h00, 4'h0, 4'd0,  1'b0, 1'b0, 4'd0, 3'd0};
    rows[6]  = '{KIND_HSK, HSK_STALL, 7'h00, 4'h0, 4'd0,  1'b0, 1'b0, 4'd0, 3'd0};
    // Data rows, typ 0 is DATA0 and 1 is DATA1
    rows[7]  = '{KIND_DAT, 2'd0,      7'h00, 4'h0, 4'd1,  1'b0, 1'b0, 4'd0, 3'd0};
    rows[8]  = '{KIND_DAT, 2'd1,      7'h00, 4'h0, 4'd12, 1'b1, 1'b0, 4'd0, 3'd0};
    rows[9]  = '{KIND_DAT, 2'd0,      7'h00, 4'h0, 4'd12, 1'b1, 1'b0, 4'd0, 3'd0};
    rows[10] = '{KIND_DAT, 2'd1,      7'h00, 4'h0, 4'd7,  1'b0, 1'b0, 4'd0, 3'd0};
    rows[11] = '{KIND_TOK, TOK_IN,    7'h03, 4'h2, 4'd0,  1'b0, 1'b1, 4'd2, 3'd4};
    rows[12] = '{KIND_HSK, HSK_NAK,   7'h00, 4'h0, 4'd0,  1'b0, 1'b1, 4'd0, 3'd1};
    rows[13] = '{KIND_DAT, 2'd0,      7'h00, 4'h0, 4'd5,  1'b0, 1'b1, 4'd3, 3'd0};
    rows[14] = '{KIND_DAT, 2'd1,      7'h00, 4'h0, 4'd4,  1'b0, 1'b1, 4'd6, 3'd7};
    rows[15] = '{KIND_DAT, 2'd0,      7'h00, 4'h0, 4'd9,  1'b0, 1'b0, 4'd0, 3'd0};
  endtask

  // TX FIFO filler with random gaps between beats
  task automatic feed_payload(input logic [7:0] p [16], input int n);
    for (int k = 0; k < n; k++) begin
      dat_tvalid_i = 1'b1;
      dat_tdata_i  = p[k];
      dat_tlast_i  = (k == n - 1);
      @(posedge clock);
      while (!dat_tready_o) @(posedge clock);
      #1;
      dat_tvalid_i = 1'b0;
      feed_rng = xorshift32(feed_rng);
      if (feed_rng[0]) wait_tick();
    end
  endtask

  task automatic run_row(input int idx);
    row_t        r;
    logic [7:0]  pay [16];
    logic [8:0]  exp_tx [$];
    logic [15:0] crc;
    logic [7:0]  b;
    logic        exp_tok, exp_sof, exp_hsk;
    r = rows[idx];
    tx_seen.delete();
    tok_cnt = 0;
    sof_cnt = 0;
    hsk_cnt = 0;
    crc_err_cnt = 0;
    corrupt_en   = r.corrupt;
    corrupt_byte = r.cbyte;
    corrupt_bit  = r.cbit;
    if (r.stall) hold_out = 1'b1;
    exp_tx.push_back({r.kind == KIND_HSK, make_pid(r.kind, r.typ)});
    case (r.kind)
      KIND_HSK: begin
        hsk_type_i = hsk_type_t'(r.typ);
        hsk_send_i = 1'b1;
        do wait_tick(); while (!hsk_done_o);
        hsk_send_i = 1'b0;
      end
      KIND_TOK: begin
        exp_tx.push_back({1'b0, r.endp[0], r.addr});
        exp_tx.push_back({1'b1, crc5_field({r.endp, r.addr}), r.endp[3:1]});
        tok_type_i = tok_type_t'(r.typ);
        tok_addr_i = r.addr;
        tok_endp_i = r.endp;
        tok_send_i = 1'b1;
        do wait_tick(); while (!tok_done_o);
        tok_send_i = 1'b0;
      end
      default: begin
        crc = 16'hffff;
        for (int k = 0; k < r.len; k++) begin
          rng = xorshift32(rng);
          pay[k] = rng[7:0];
          crc = crc16_step(crc, pay[k]);
          exp_tx.push_back({1'b0, pay[k]});
          if (!r.corrupt) begin
            exp_q.push_back({r.typ[0], k == r.len - 1, pay[k]});
          end else if (r.cbyte != 0 && k < r.len - 1) begin
            // Bad CRC keeps the earlier beats but drops the one with tlast
            b = pay[k] ^ ((r.cbyte == k + 1) ? (8'h01 << r.cbit) : 8'h00);
            exp_q.push_back({r.typ[0], 1'b0, b});
          end
        end
        crc = ~crc;
        exp_tx.push_back({1'b0, crc[7:0]});
        exp_tx.push_back({1'b1, crc[15:8]});
        dat_type_i = dat_type_t'(r.typ[0]);
        fork
          feed_payload(pay, r.len);
          begin
            dat_send_i = 1'b1;
            do wait_tick(); while (!dat_done_o);
            dat_send_i = 1'b0;
          end
        join
      end
    endcase
    repeat (2) wait_tick();
    assert (tx_seen.size() == exp_tx.size())
    else report_error($sformatf("row %0d sent %0d bytes, expected %0d",
                                idx, tx_seen.size(), exp_tx.size()));
    foreach (exp_tx[i]) begin
      assert (tx_seen[i] == exp_tx[i])
      else report_error($sformatf("row %0d byte %0d is %h, expected %h",
                                  idx, i, tx_seen[i], exp_tx[i]));
    end
    exp_tok = (r.kind == KIND_TOK) && !r.corrupt && (r.typ != TOK_SOF);
    exp_sof = (r.kind == KIND_TOK) && !r.corrupt && (r.typ == TOK_SOF);
    exp_hsk = (r.kind == KIND_HSK) && !r.corrupt;
    assert (tok_cnt == exp_tok && sof_cnt == exp_sof && hsk_cnt == exp_hsk
            && crc_err_cnt == r.corrupt)
    else report_error($sformatf("row %0d events tok %0d sof %0d hsk %0d err %0d",
                                idx, tok_cnt, sof_cnt, hsk_cnt, crc_err_cnt));
    if (exp_tok) begin
      assert (seen_tok_type == r.typ && seen_addr == r.addr && seen_endp == r.endp)
      else report_error($sformatf("row %0d token fields %0d %h %h", idx,
                                  seen_tok_type, seen_addr, seen_endp));
    end
    if (exp_hsk) begin
      assert (seen_hsk_type == r.typ)
      else report_error($sformatf("row %0d handshake type %0d", idx, seen_hsk_type));
    end
    corrupt_en = 1'b0;
  endtask

  // Gate stalls, corruption byte index and out_tready, all driven after the edge
  always @(posedge clock) begin
    logic fired;
    logic fired_last;
    fired      = usb_tx_tvalid_o && usb_tx_tready_i;
    fired_last = fired && usb_tx_tlast_o;
    #1;
    if (fired_last) begin
      byte_idx = '0;
    end else if (fired) begin
      byte_idx = byte_idx + 1'b1;
    end
    gate_rng     = xorshift32(gate_rng);
    gate_stall   = (gate_rng[1:0] == 2'b00);
    out_tready_i = !hold_out;
  end

  always @(posedge clock) begin
    logic [9:0] exp_beat;
    if (rst_n_i) begin
      if (usb_tx_tvalid_o && usb_tx_tready_i) tx_seen.push_back({usb_tx_tlast_o, usb_tx_tdata_o});
      if (tok_recv_o) begin
        tok_cnt++;
        seen_tok_type = tok_type_o;
        seen_addr = tok_addr_o;
        seen_endp = tok_endp_o;
      end
      if (usb_sof_o) sof_cnt++;
      if (hsk_recv_o) begin
        hsk_cnt++;
        seen_hsk_type = hsk_type_o;
      end
      if (crc_err_o) crc_err_cnt++;
      if (out_tvalid_o && out_tready_i) begin
        assert (exp_q.size() != 0) else report_error("payload beat arrived with none expected");
        exp_beat = exp_q.pop_front();
        assert ({out_ttype_o, out_tlast_o, out_tdata_o} == exp_beat)
        else report_error($sformatf("payload beat %h, expected %h",
                                    {out_ttype_o, out_tlast_o, out_tdata_o}, exp_beat));
      end
      // RX FIFO is full, let it drain
      if (!usb_rx_tready_o) hold_out = 1'b0;
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Run timed out before all rows finished");
    $display("SOME TESTS FAILED");
    $fatal(1);
  end

  initial begin
    rst_n_i = 1'b0;
    hsk_send_i = 1'b0;
    hsk_type_i = HSK_ACK;
    tok_send_i = 1'b0;
    tok_type_i = TOK_OUT;
    tok_addr_i = '0;
    tok_endp_i = '0;
    dat_send_i = 1'b0;
    dat_type_i = DATA0;
    dat_tvalid_i = 1'b0;
    dat_tlast_i = 1'b0;
    dat_tdata_i = '0;
    out_tready_i = 1'b1;
    load_table();
    repeat (2) @(posedge clock);
    #1;
    rst_n_i = 1'b1;
    wait_tick();
    for (int i = 0; i < NROWS; i++) begin
      run_row(i);
    end
    hold_out = 1'b0;
    while (exp_q.size() != 0) wait_tick();
    repeat (4) wait_tick();
    if (UUT.u_encode.enc_chk.fail_cnt == 0 && UUT.u_decode.dec_chk.fail_cnt == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      $display("SOME TESTS FAILED");
      $fatal(1);
    end
  end

endmodule

// ==== usb_packet_codec.f ====
+incdir+rtl
rtl/usb_pkg.sv
rtl/usb_stream_if.sv
rtl/usb_crc16.sv
rtl/usb_stream_fifo.sv
rtl/encode_packet.sv
rtl/decode_packet.sv
rtl/usb_packet_codec.sv
tests/usb_packet_codec_chk.sv
tests/usb_packet_codec_tb.sv
